//--- rtl/bridge_config.svh
/*
  Build-wide sizes for the processor-to-fabric bridge.
  Included by the packages and by any module that needs bank count or widths.
*/

`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// System bus and AXI4-Lite widths
`define SYS_AW 32
`define SYS_DW 32

// Register banks behind the decoder
`define NUM_BANKS 3

// Identification value of bank 0, later banks add their index
`define BANK_ID_BASE 32'hB41F_0000

`endif

//--- rtl/axi_lite_pkg.sv
/*
  AXI4-Lite channel payloads and response codes.
  Ports name these types by scope; module bodies import the package.
*/

`default_nettype none

`include "bridge_config.svh"

package axi_lite_pkg;

  // Plain vectors
  typedef logic [`SYS_AW-1:0]   axi_addr_t;
  typedef logic [`SYS_DW-1:0]   axi_data_t;
  typedef logic [`SYS_DW/8-1:0] axi_strb_t;
  typedef logic [1:0]           axi_resp_t;

  // Response codes in use, no EXOKAY or DECERR
  localparam axi_resp_t resp_okay   = 2'd0;
  localparam axi_resp_t resp_slverr = 2'd2;

  // Channel payloads
  typedef struct packed {axi_addr_t addr;} axi_aw_t;
  typedef struct packed {axi_data_t data; axi_strb_t strb;} axi_w_t;
  typedef struct packed {axi_addr_t addr;} axi_ar_t;
  typedef struct packed {axi_resp_t resp;} axi_b_t;
  typedef struct packed {axi_data_t data; axi_resp_t resp;} axi_r_t;

endpackage

`default_nettype wire

//--- rtl/sys_bus_pkg.sv
/*
  Simple system bus types shared by slave, decoder and register banks.
  One strobe cycle per request, one ack cycle per answer.
*/

`default_nettype none

`include "bridge_config.svh"

package sys_bus_pkg;

  typedef logic [`SYS_AW-1:0]   sys_addr_t;
  typedef logic [`SYS_DW-1:0]   sys_data_t;
  typedef logic [`SYS_DW/8-1:0] sys_sel_t;

  // Bank from addr[15:12], register from addr[3:2]
  typedef logic [3:0] bank_idx_t;
  typedef logic [1:0] reg_idx_t;

  // Request, wen and ren are single-cycle strobes
  typedef struct packed {
    sys_addr_t addr;
    sys_data_t wdata;
    sys_sel_t  sel;
    logic      wen;
    logic      ren;
  } sys_req_t;

  // Answer, rdata and err only meaningful with ack
  typedef struct packed {
    sys_data_t rdata;
    logic      err;
    logic      ack;
  } sys_rsp_t;

endpackage

`default_nettype wire

//--- rtl/axi_slave.sv
/*
  AXI4-Lite slave acting as master of the system bus.
  One transaction in flight; a write wins over a read pending in the same cycle.
  Strobe one cycle after accept, response valid one cycle after the ack.
*/

`timescale 1ns/10ps
`default_nettype none

module axi_slave (
  input  wire                      clk,
  input  wire                      rst_n,
  // Write address and data
  input  wire axi_lite_pkg::axi_aw_t aw,
  input  wire                      aw_valid,
  output logic                     aw_ready,
  input  wire axi_lite_pkg::axi_w_t  w,
  input  wire                      w_valid,
  output logic                     w_ready,
  // Read address
  input  wire axi_lite_pkg::axi_ar_t ar,
  input  wire                      ar_valid,
  output logic                     ar_ready,
  // Responses
  output axi_lite_pkg::axi_b_t     b,
  output logic                     b_valid,
  input  wire                      b_ready,
  output axi_lite_pkg::axi_r_t     r,
  output logic                     r_valid,
  input  wire                      r_ready,
  // System bus
  output sys_bus_pkg::sys_req_t    req,
  input  wire sys_bus_pkg::sys_rsp_t rsp
);

  import axi_lite_pkg::*;
  import sys_bus_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait_ack,
    st_respond
  } state_t;

  state_t    state;
  logic      is_write;
  logic      wr_take;
  logic      rd_take;
  logic      resp_take;
  axi_addr_t addr_q;
  axi_data_t wdata_q;
  axi_strb_t strb_q;
  axi_data_t rdata_q;
  axi_resp_t resp_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request half
  ////////////////////////////////////////////////////////////////////////////

  // Write needs both address and data present
  assign wr_take = (state == st_idle) && aw_valid && w_valid;
  // Read only when no full write is waiting
  assign rd_take = (state == st_idle) && ar_valid && !(aw_valid && w_valid);

  assign aw_ready = wr_take;
  assign w_ready  = wr_take;
  assign ar_ready = rd_take;

  // Master took b or r
  assign resp_take = (is_write && b_ready) || (!is_write && r_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      is_write <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (wr_take || rd_take) begin
            is_write <= wr_take;
            state    <= st_issue;
          end
        end
        // Strobe is out this cycle
        st_issue: state <= st_wait_ack;
        st_wait_ack: begin
          if (rsp.ack) begin
            state <= st_respond;
          end
        end
        // Hold until the master is ready
        st_respond: begin
          if (resp_take) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Captured transaction and answer
  always_ff @(posedge clk) begin
    if (wr_take) begin
      addr_q  <= aw.addr;
      wdata_q <= w.data;
      strb_q  <= w.strb;
    end else if (rd_take) begin
      addr_q <= ar.addr;
    end
    if ((state == st_wait_ack) && rsp.ack) begin
      rdata_q <= rsp.rdata;
      resp_q  <= rsp.err ? resp_slverr : resp_okay;
    end
  end

  // Single-cycle strobe in st_issue
  assign req = '{addr:  sys_addr_t'(addr_q),
                 wdata: sys_data_t'(wdata_q),
                 sel:   sys_sel_t'(strb_q),
                 wen:   (state == st_issue) && is_write,
                 ren:   (state == st_issue) && !is_write};

  ////////////////////////////////////////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////////////////////////////////////////

  assign b_valid = (state == st_respond) && is_write;
  assign b       = '{resp: resp_q};
  assign r_valid = (state == st_respond) && !is_write;
  assign r       = '{data: rdata_q, resp: resp_q};

endmodule

`default_nettype wire

//--- rtl/sys_bus_decoder.sv
/*
  System bus decoder, one request in, one request per register bank out.
  Unmapped bank indices get a registered error ack one cycle after the strobe.
*/

`timescale 1ns/10ps
`default_nettype none

`include "bridge_config.svh"

module sys_bus_decoder (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire sys_bus_pkg::sys_req_t req,
  output sys_bus_pkg::sys_rsp_t      rsp,
  output sys_bus_pkg::sys_req_t      bank_req [`NUM_BANKS],
  input  wire sys_bus_pkg::sys_rsp_t bank_rsp [`NUM_BANKS]
);

  import sys_bus_pkg::*;

  bank_idx_t bank_idx;
  logic      hit;
  logic      err_ack;

  // Bank field of the address
  assign bank_idx = bank_idx_t'(req.addr[15:12]);
  assign hit      = (bank_idx < bank_idx_t'(`NUM_BANKS));

  // Strobes only reach the addressed bank
  always_comb begin
    for (int i = 0; i < `NUM_BANKS; i++) begin
      bank_req[i] = req;
      if (bank_idx != bank_idx_t'(i)) begin
        bank_req[i].wen = 1'b0;
        bank_req[i].ren = 1'b0;
      end
    end
  end

  // Error ack for strobes nobody answers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_ack <= 1'b0;
    end else begin
      err_ack <= (req.wen || req.ren) && !hit;
    end
  end

  // Address is held by the slave until the ack, so the same index picks the answer
  always_comb begin
    rsp = '0;
    for (int i = 0; i < `NUM_BANKS; i++) begin
      if (bank_idx == bank_idx_t'(i)) begin
        rsp = bank_rsp[i];
      end
    end
    if (!hit) begin
      rsp.rdata = '0;
      rsp.err   = err_ack;
      rsp.ack   = err_ack;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reg_bank.sv
/*
  Register bank, three byte-writable registers and a read-only ID register.
  Every strobe is acked one cycle later without error.
*/

`timescale 1ns/10ps
`default_nettype none

`include "bridge_config.svh"

module reg_bank #(
  parameter int unsigned bank_index = 0
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire sys_bus_pkg::sys_req_t req,
  output sys_bus_pkg::sys_rsp_t      rsp
);

  import sys_bus_pkg::*;

  sys_data_t regs [3];
  sys_data_t rd_mux;
  sys_data_t rdata_q;
  reg_idx_t  reg_idx;
  logic      ack_q;

  assign reg_idx = reg_idx_t'(req.addr[3:2]);

  // Register 3 is the identification word
  assign rd_mux = (reg_idx == 2'd3) ? sys_data_t'(`BANK_ID_BASE + bank_index)
                                    : regs[reg_idx];

  // Byte writes, writes to the ID slot are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++) begin
        regs[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.wen || req.ren;
      if (req.wen && (reg_idx != 2'd3)) begin
        for (int b = 0; b < `SYS_DW/8; b++) begin
          if (req.sel[b]) begin
            regs[reg_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clk) begin
    if (req.ren) begin
      rdata_q <= rd_mux;
    end
  end

  assign rsp = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

endmodule

`default_nettype wire

//--- rtl/ps_bridge_top.sv
/*
  Bridge top, AXI4-Lite slave in front of the decoder and the register banks.
*/

`timescale 1ns/10ps
`default_nettype none

`include "bridge_config.svh"

module ps_bridge_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire axi_lite_pkg::axi_aw_t aw,
  input  wire                        aw_valid,
  output logic                       aw_ready,
  input  wire axi_lite_pkg::axi_w_t  w,
  input  wire                        w_valid,
  output logic                       w_ready,
  input  wire axi_lite_pkg::axi_ar_t ar,
  input  wire                        ar_valid,
  output logic                       ar_ready,
  output axi_lite_pkg::axi_b_t       b,
  output logic                       b_valid,
  input  wire                        b_ready,
  output axi_lite_pkg::axi_r_t       r,
  output logic                       r_valid,
  input  wire                        r_ready
);

  import sys_bus_pkg::*;

  sys_req_t sys_req;
  sys_rsp_t sys_rsp;
  sys_req_t bank_req [`NUM_BANKS];
  sys_rsp_t bank_rsp [`NUM_BANKS];

  // AXI side
  axi_slave u_axi_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .req      (sys_req),
    .rsp      (sys_rsp)
  );

  sys_bus_decoder u_decoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (sys_req),
    .rsp      (sys_rsp),
    .bank_req (bank_req),
    .bank_rsp (bank_rsp)
  );

  // One bank per decoder slot
  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    reg_bank #(
      .bank_index (i)
    ) u_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (bank_req[i]),
      .rsp   (bank_rsp[i])
    );
  end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
/*
  Testbench clock and reset source.
  20 ns clock; rst_n is held low for the first 10 rising edges.
*/

`timescale 1ns/10ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release on a rising edge, like the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_ps_bridge.sv
/*
  Testbench for the bridge top level. A table of AXI4-Lite writes and reads
  with expected responses is played in order, with random bready and rready
  hold-off; a watchdog bounds the run.
*/

`timescale 1ns/10ps
`default_nettype none

`include "bridge_config.svh"

module tb_ps_bridge;

  import axi_lite_pkg::*;

  typedef struct packed {
    logic      is_write;
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    axi_data_t exp_data;
    axi_resp_t exp_resp;
  } test_t;

  logic    clk;
  logic    rst_n;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;

  test_t  tests_q[$];
  logic   tests_ready = 1'b0;
  integer seed = 61881;
  int     check_count = 0;
  int     error_count = 0;

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  ps_bridge_top DUT (
    .clk(clk), .rst_n(rst_n),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready)
  );

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Bank in addr[15:12], register in addr[3:2]
  function automatic axi_addr_t reg_addr(input int bank, input int idx);
    return axi_addr_t'((bank << 12) | (idx << 2));
  endfunction

  function automatic void queue_write(input axi_addr_t addr, input axi_data_t data,
                                      input axi_strb_t strb, input axi_resp_t resp);
    test_t entry;
    entry = '{is_write: 1'b1, addr: addr, data: data, strb: strb,
              exp_data: '0, exp_resp: resp};
    tests_q.push_back(entry);
  endfunction

  function automatic void queue_read(input axi_addr_t addr, input axi_data_t exp_data,
                                     input axi_resp_t resp);
    test_t entry;
    entry = '{is_write: 1'b0, addr: addr, data: '0, strb: '0,
              exp_data: exp_data, exp_resp: resp};
    tests_q.push_back(entry);
  endfunction

  // Data in the upper bits, response code in the lower two
  function automatic logic [33:0] response_payload(input logic is_write);
    if (is_write) begin
      return {32'h0, b.resp};
    end
    return {r.data, r.resp};
  endfunction

  function automatic logic response_valid(input logic is_write);
    return is_write ? b_valid : r_valid;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////////

  task automatic build_tests();
    // Everything reads zero out of reset
    for (int k = 0; k < `NUM_BANKS; k++) begin
      for (int n = 0; n < 3; n++) begin
        queue_read(reg_addr(k, n), '0, resp_okay);
      end
    end
    // Full-strobe writes to one register in each bank
    queue_write(reg_addr(0, 0), 32'h1122_3344, 4'hF, resp_okay);
    queue_write(reg_addr(1, 2), 32'hCAFE_F00D, 4'hF, resp_okay);
    queue_write(reg_addr(2, 1), 32'h0BAD_BEEF, 4'hF, resp_okay);
    queue_read(reg_addr(0, 0), 32'h1122_3344, resp_okay);
    queue_read(reg_addr(1, 2), 32'hCAFE_F00D, resp_okay);
    queue_read(reg_addr(2, 1), 32'h0BAD_BEEF, resp_okay);
    // Neighbours keep their reset value
    queue_read(reg_addr(0, 1), '0, resp_okay);
    queue_read(reg_addr(1, 0), '0, resp_okay);
    queue_read(reg_addr(2, 2), '0, resp_okay);
    // Byte merge of old and new data
    queue_write(reg_addr(0, 0), 32'hAABB_CCDD, 4'b0101, resp_okay);
    queue_read(reg_addr(0, 0), 32'h11BB_33DD, resp_okay);
    queue_write(reg_addr(1, 2), 32'h1234_5678, 4'b1000, resp_okay);
    queue_read(reg_addr(1, 2), 32'h12FE_F00D, resp_okay);
    // ID words read base plus bank index and ignore writes
    for (int k = 0; k < `NUM_BANKS; k++) begin
      queue_read(reg_addr(k, 3), axi_data_t'(`BANK_ID_BASE + k), resp_okay);
    end
    queue_write(reg_addr(1, 3), 32'hFFFF_FFFF, 4'hF, resp_okay);
    queue_read(reg_addr(1, 3), axi_data_t'(`BANK_ID_BASE + 1), resp_okay);
    // Unmapped banks answer SLVERR with zero data
    queue_write(reg_addr(`NUM_BANKS, 0), 32'h5555_AAAA, 4'hF, resp_slverr);
    queue_read(reg_addr(`NUM_BANKS, 0), '0, resp_slverr);
    queue_write(reg_addr(15, 1), 32'hA5A5_5A5A, 4'hF, resp_slverr);
    queue_read(reg_addr(15, 2), '0, resp_slverr);
    queue_read(reg_addr(0, 0), 32'h11BB_33DD, resp_okay);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // One AXI4-Lite transaction
  //////////////////////////////////////////////////////////////////////////

  task automatic run_test(input test_t t, input int idx);
    int          delay;
    logic [33:0] held;
    @(posedge clk);
    if (t.is_write) begin
      aw       <= '{addr: t.addr};
      w        <= '{data: t.data, strb: t.strb};
      aw_valid <= 1'b1;
      w_valid  <= 1'b1;
    end else begin
      ar       <= '{addr: t.addr};
      ar_valid <= 1'b1;
    end
    // Address phase ends on the edge where ready was seen
    @(posedge clk);
    while (!(t.is_write ? (aw_ready && w_ready) : ar_ready)) @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    ar_valid <= 1'b0;
    // Response arrives with ready still low
    @(posedge clk);
    while (!response_valid(t.is_write)) @(posedge clk);
    held  = response_payload(t.is_write);
    delay = $random(seed) & 3;
    // Payload must hold while the master stalls
    repeat (delay) begin
      @(posedge clk);
      check_value(response_valid(t.is_write), 1, $sformatf("test %0d valid dropped", idx));
      check_value(response_payload(t.is_write), held,
                  $sformatf("test %0d payload changed while stalled", idx));
    end
    if (t.is_write) begin
      b_ready <= 1'b1;
    end else begin
      r_ready <= 1'b1;
    end
    @(posedge clk);
    check_value(response_valid(t.is_write), 1, $sformatf("test %0d valid at transfer", idx));
    check_value(response_payload(t.is_write), held,
                $sformatf("test %0d payload at transfer", idx));
    b_ready <= 1'b0;
    r_ready <= 1'b0;
    check_value(held[1:0], t.exp_resp, $sformatf("test %0d response code", idx));
    if (!t.is_write) begin
      check_value(held[33:2], t.exp_data, $sformatf("test %0d read data", idx));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial begin
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    build_tests();
    tests_ready = 1'b1;
    wait (rst_n === 1'b1);
    @(posedge clk);
    // Idle bridge after reset
    check_value(aw_ready, 0, "aw_ready after reset");
    check_value(w_ready, 0, "w_ready after reset");
    check_value(ar_ready, 0, "ar_ready after reset");
    check_value(b_valid, 0, "b_valid after reset");
    check_value(r_valid, 0, "r_valid after reset");
    for (int i = 0; i < tests_q.size(); i++) begin
      run_test(tests_q[i], i);
    end
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Bound of 40 cycles per table entry and 20 for reset at 20 ns per cycle
  initial begin
    wait (tests_ready);
    #((tests_q.size() * 40 + 20) * 20);
    $display("Watchdog timeout: the bridge stopped answering, %0d errors so far",
             error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/axi_lite_pkg.sv
rtl/sys_bus_pkg.sv
rtl/axi_slave.sv
rtl/sys_bus_decoder.sv
rtl/reg_bank.sv
rtl/ps_bridge_top.sv
sim/clk_gen.sv
sim/tb_ps_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ps_bridge -f list.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

# A crashed run counts as a failed one
./obj_dir/Vtb_ps_bridge > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No result line in log"; exit 1; }
exit 0
